/* design/nocMacros.svh */
`ifndef NOC_MACROS_SVH
`define NOC_MACROS_SVH

// ========================================
// Router port geometry
// ========================================

// Local, North, East, West, South
`define NOC_PORTS     5

// Entries per input queue and the initial downstream credits
`define NOC_QDEPTH    4

`define NOC_PAYLOAD_W 16

// Hold budget field in the low payload bits of a head flit
`define NOC_LEN_W     12

`define NOC_CREDIT_W  3

`endif

/* design/arbPkg.sv */
`include "nocMacros.svh"

package arbPkg;

  typedef logic [2:0]            portIdxT;
  typedef logic [`NOC_PORTS-1:0] portMaskT;

  localparam portIdxT PORT_L = 3'd0;
  localparam portIdxT PORT_N = 3'd1;
  localparam portIdxT PORT_E = 3'd2;
  localparam portIdxT PORT_W = 3'd3;
  localparam portIdxT PORT_S = 3'd4;

  // Bit 0 is idle and bit i+1 grants port i
  typedef enum logic [`NOC_PORTS:0] {
    ARB_IDLE = 6'b000001,
    ARB_L    = 6'b000010,
    ARB_N    = 6'b000100,
    ARB_E    = 6'b001000,
    ARB_W    = 6'b010000,
    ARB_S    = 6'b100000
  } arbStateT;

endpackage

/* design/flitPkg.sv */
`include "nocMacros.svh"

package flitPkg;

  typedef enum logic [2:0] {
    FLIT_IDLE = 3'b000,
    FLIT_HEAD = 3'b001,
    FLIT_BODY = 3'b010,
    FLIT_TAIL = 3'b100
  } flitKindT;

  typedef logic [`NOC_PAYLOAD_W-1:0] payloadT;
  typedef logic [`NOC_LEN_W-1:0]     holdLenT;

  // 19 bits on the wire
  typedef struct packed {
    flitKindT kind;
    payloadT  payload;
  } flitT;

  // Flit leaving the port with its input tag
  typedef struct packed {
    flitT            flit;
    arbPkg::portIdxT src;
  } outFlitT;

endpackage

/* design/inputQueue.sv */
`timescale 1ns/1ps
`include "nocMacros.svh"

module inputQueue (
  input  logic          clk,
  input  logic          rst,
  input  flitPkg::flitT inFlit,
  input  logic          inValid,
  input  logic          pop,
  output flitPkg::flitT headFlit,
  output logic          notEmpty,
  output logic          creditOut
);

  import flitPkg::*;

  localparam int ptrW = $clog2(`NOC_QDEPTH);

  flitT            mem [`NOC_QDEPTH];
  logic [ptrW-1:0] wrPtr;
  logic [ptrW-1:0] rdPtr;
  logic [ptrW:0]   fill;
  logic            full;
  logic            doWrite;
  logic            doRead;

  assign full     = (fill == (ptrW+1)'(`NOC_QDEPTH));
  assign notEmpty = (fill != '0);
  assign doRead   = pop && notEmpty;
  assign doWrite  = inValid && (!full || doRead); // Slot frees on the same edge

  assign headFlit  = mem[rdPtr];
  assign creditOut = doRead;   // One credit back per popped flit

  always_ff @(posedge clk)
  begin
    if (doWrite)
      mem[wrPtr] <= inFlit;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wrPtr <= '0;
      rdPtr <= '0;
      fill  <= '0;
    end
    else
    begin
      if (doWrite)
        wrPtr <= wrPtr + 1'b1;
      if (doRead)
        rdPtr <= rdPtr + 1'b1;

      case ({doWrite, doRead})
        2'b10:   fill <= fill + 1'b1;
        2'b01:   fill <= fill - 1'b1;
        default: fill <= fill;
      endcase
    end
  end

endmodule

/* design/flitDecoder.sv */
`timescale 1ns/1ps
`include "nocMacros.svh"

module flitDecoder (
  input  flitPkg::flitT         headFlit [`NOC_PORTS],
  input  logic [`NOC_PORTS-1:0] notEmpty,
  output arbPkg::portMaskT      reqMask,
  output arbPkg::portMaskT      headMask,
  output flitPkg::holdLenT      budget [`NOC_PORTS]
);

  import flitPkg::*;

  flitKindT kind [`NOC_PORTS];
  logic     isHead [`NOC_PORTS];

  always_comb
  begin
    for (int i = 0; i < `NOC_PORTS; i++)
    begin
      kind[i]   = headFlit[i].kind;
      isHead[i] = 1'b0;

      // Any non-empty queue requests, whatever its head holds
      reqMask[i] = notEmpty[i];

      case (kind[i])
        FLIT_HEAD:
          isHead[i] = notEmpty[i];
        FLIT_BODY,
        FLIT_TAIL:
          isHead[i] = 1'b0;
        default:
          isHead[i] = 1'b0;   // Idle or illegal kind drains as filler
      endcase

      headMask[i] = isHead[i];

      if (isHead[i])
        budget[i] = headFlit[i].payload[`NOC_LEN_W-1:0];
      else
        budget[i] = '0;
    end
  end

endmodule

/* design/holdTimer.sv */
`timescale 1ns/1ps
`include "nocMacros.svh"

module holdTimer (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  load,
  input  logic [`NOC_LEN_W-1:0] budget,
  input  logic                  granted,
  input  logic                  step,
  output logic                  timesUp
);

  logic [`NOC_LEN_W-1:0] limit;
  logic [`NOC_LEN_W-1:0] count;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      limit <= `NOC_LEN_W'(1);
      count <= '0;
    end
    else
    begin
      if (load)
        limit <= (budget == '0) ? `NOC_LEN_W'(1) : budget;   // Zero acts as one

      // An expired hold restarts if the same input wins again
      if (!granted || timesUp)
        count <= '0;
      else if (load)
        count <= `NOC_LEN_W'(1);
      else if (step)
        count <= count + 1'b1;
    end
  end

  assign timesUp = granted && (count == limit);

endmodule

/* design/portArbiter.sv */
`timescale 1ns/1ps
`include "nocMacros.svh"

module portArbiter (
  input  logic             clk,
  input  logic             rst,
  input  arbPkg::portMaskT reqMask,
  input  arbPkg::portMaskT headMask,
  input  flitPkg::holdLenT budget [`NOC_PORTS],
  input  logic             hasCredit,
  output arbPkg::portMaskT grantMask,
  output logic             fwd
);

  import arbPkg::*;

  arbStateT state;
  arbStateT nextState;
  portIdxT  curIdx;
  logic     inGrant;
  portMaskT timesUp;
  portMaskT step;
  portMaskT load;

  // First requester after last, ending with last itself
  function automatic arbStateT pickNext(portMaskT req, portIdxT last);
    arbStateT pick;
    portIdxT  idx;
    pick = ARB_IDLE;
    idx  = last;
    for (int k = 0; k < `NOC_PORTS; k++)
    begin
      idx = (idx == PORT_S) ? PORT_L : idx + 3'd1;
      if (req[idx] && (pick == ARB_IDLE))
        pick = arbStateT'((`NOC_PORTS+1)'(2) << idx);
    end
    return pick;
  endfunction

  // ========================================
  // Grant state machine
  // ========================================

  always_comb
  begin
    inGrant = 1'b1;
    curIdx  = PORT_S;
    case (state)
      ARB_L:   curIdx = PORT_L;
      ARB_N:   curIdx = PORT_N;
      ARB_E:   curIdx = PORT_E;
      ARB_W:   curIdx = PORT_W;
      ARB_S:   curIdx = PORT_S;
      default: inGrant = 1'b0;   // From idle the scan starts at L
    endcase
  end

  always_comb
  begin
    if (inGrant && reqMask[curIdx] && !timesUp[curIdx])
      nextState = state;
    else
      nextState = pickNext(reqMask, curIdx);
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      state <= ARB_IDLE;
    else
      state <= nextState;
  end

  assign grantMask = state[`NOC_PORTS:1];

  // An expired input sends nothing more on this grant
  assign fwd = hasCredit && (|(grantMask & reqMask & ~timesUp));

  // ========================================
  // Per-input hold timers
  // ========================================

  assign step = grantMask & {`NOC_PORTS{fwd}};
  assign load = step & headMask;

  for (genvar i = 0; i < `NOC_PORTS; i++)
  begin : genTimer
    holdTimer timer (
      .clk     (clk),
      .rst     (rst),
      .load    (load[i]),
      .budget  (budget[i]),
      .granted (grantMask[i]),
      .step    (step[i]),
      .timesUp (timesUp[i])
    );
  end

endmodule

/* design/outputStage.sv */
`timescale 1ns/1ps
`include "nocMacros.svh"

module outputStage (
  input  logic             clk,
  input  logic             rst,
  input  flitPkg::flitT    headFlit [`NOC_PORTS],
  input  arbPkg::portMaskT grantMask,
  input  logic             fwd,
  input  logic             creditIn,
  output flitPkg::outFlitT outFlit,
  output logic             outValid,
  output logic             hasCredit
);

  import flitPkg::*;
  import arbPkg::*;

  flitT                     selFlit;
  portIdxT                  selSrc;
  logic [`NOC_CREDIT_W-1:0] credits;

  // ========================================
  // Grant mux and source encode
  // ========================================

  always_comb
  begin
    selFlit = '0;
    selSrc  = PORT_L;
    for (int i = 0; i < `NOC_PORTS; i++)
    begin
      if (grantMask[i])
      begin
        selFlit = headFlit[i];
        selSrc  = portIdxT'(i);
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (fwd)
    begin
      outFlit.flit <= selFlit;
      outFlit.src  <= selSrc;
    end
  end

  // ========================================
  // Downstream credits
  // ========================================

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      outValid <= 1'b0;
      credits  <= `NOC_CREDIT_W'(`NOC_QDEPTH);
    end
    else
    begin
      outValid <= fwd;   // Valid for the one cycle after the pop
      case ({outValid, creditIn})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: credits <= credits;
      endcase
    end
  end

  // The flit now in the register has already used one credit
  assign hasCredit = (credits > `NOC_CREDIT_W'(outValid));

endmodule

/* design/routerOutPort.sv */
`timescale 1ns/1ps
`include "nocMacros.svh"

module routerOutPort (
  input  logic                  clk,
  input  logic                  rst,
  input  flitPkg::flitT         inFlit [`NOC_PORTS],
  input  logic [`NOC_PORTS-1:0] inValid,
  output logic [`NOC_PORTS-1:0] creditOut,
  output flitPkg::outFlitT      outFlit,
  output logic                  outValid,
  input  logic                  creditIn
);

  import flitPkg::*;
  import arbPkg::*;

  flitT     headFlit [`NOC_PORTS];
  holdLenT  budget [`NOC_PORTS];
  portMaskT notEmpty;
  portMaskT reqMask;
  portMaskT headMask;
  portMaskT grantMask;
  portMaskT pop;
  logic     fwd;
  logic     hasCredit;

  assign pop = grantMask & {`NOC_PORTS{fwd}};

  for (genvar i = 0; i < `NOC_PORTS; i++)
  begin : genQueue
    inputQueue queue (
      .clk       (clk),
      .rst       (rst),
      .inFlit    (inFlit[i]),
      .inValid   (inValid[i]),
      .pop       (pop[i]),
      .headFlit  (headFlit[i]),
      .notEmpty  (notEmpty[i]),
      .creditOut (creditOut[i])
    );
  end

  flitDecoder decoder (
    .headFlit (headFlit),
    .notEmpty (notEmpty),
    .reqMask  (reqMask),
    .headMask (headMask),
    .budget   (budget)
  );

  portArbiter arbiter (
    .clk       (clk),
    .rst       (rst),
    .reqMask   (reqMask),
    .headMask  (headMask),
    .budget    (budget),
    .hasCredit (hasCredit),
    .grantMask (grantMask),
    .fwd       (fwd)
  );

  outputStage outStage (
    .clk       (clk),
    .rst       (rst),
    .headFlit  (headFlit),
    .grantMask (grantMask),
    .fwd       (fwd),
    .creditIn  (creditIn),
    .outFlit   (outFlit),
    .outValid  (outValid),
    .hasCredit (hasCredit)
  );

endmodule

/* sim/outPortRefModel.svh */
`ifndef OUT_PORT_REF_MODEL_SVH
`define OUT_PORT_REF_MODEL_SVH

// ========================================
// Expected traffic per source
// ========================================

flitT     expQ [`NOC_PORTS][$];
int       limitOf [`NOC_PORTS] = '{default: 1};   // Timer limit out of reset
int       lastSrc = -1;
int       runLen;
portMaskT lastReq;

// Flits a source may forward per grant, as carried by its head
function automatic int refBudget(flitT head);
  int len;
  len = head.payload[`NOC_LEN_W-1:0];
  return (len == 0) ? 1 : len;
endfunction

// Rotating choice starting after last and ending with last itself
function automatic int refNextGrant(int last, portMaskT req);
  int idx;
  for (int k = 1; k <= `NOC_PORTS; k++)
  begin
    idx = (last + k) % `NOC_PORTS;
    if (req[idx])
      return idx;
  end
  return -1;
endfunction

function automatic bit othersWaiting(int src, portMaskT req);
  return (req & ~(portMaskT'(1) << src)) != '0;
endfunction

// Run has reached the budget while another input waits
function automatic bit overBudget(int src, portMaskT req);
  return (runLen == limitOf[src]) && othersWaiting(src, req);
endfunction

`endif

/* sim/routerOutPortTb.sv */
`timescale 1ns/1ps
`include "nocMacros.svh"

module routerOutPortTb;

  import flitPkg::*;
  import arbPkg::*;

  logic     clk;
  logic     rst;
  flitT     inFlit [`NOC_PORTS];
  portMaskT inValid;
  portMaskT creditOut;
  outFlitT  outFlit;
  logic     outValid;
  logic     creditIn;

  flitT     pendQ [`NOC_PORTS][$];
  int       credit [`NOC_PORTS];
  int       occ [`NOC_PORTS];
  int       sentCnt [`NOC_PORTS];
  int       creditCnt [`NOC_PORTS];
  portMaskT reqSnap;
  int       dueQ [$];
  int       delayTab [1024];
  int       cycle;
  int       lastDue;
  bit       holdCredits;
  int       outCount;
  int       rotChecks;
  int       errors;
  int       testsRun;
  int       testsFailed;

  `include "outPortRefModel.svh"

  routerOutPort UUT (
    .clk       (clk),
    .rst       (rst),
    .inFlit    (inFlit),
    .inValid   (inValid),
    .creditOut (creditOut),
    .outFlit   (outFlit),
    .outValid  (outValid),
    .creditIn  (creditIn)
  );

  always #4 clk = ~clk;

  // ========================================
  // Senders and receiver
  // ========================================

  always @(negedge clk)
  begin
    int due;
    for (int i = 0; i < `NOC_PORTS; i++)
    begin
      reqSnap[i] = (occ[i] != 0);   // Queue fill seen by the arbiter this cycle
      inValid[i] = 1'b0;
      if (creditOut[i])
      begin
        assert (credit[i] < `NOC_QDEPTH)
        else
        begin
          $display("Input %0d got a credit back for a flit it never sent", i);
          errors++;
        end
        credit[i]++;
        creditCnt[i]++;
        occ[i]--;
      end
      if (credit[i] > 0 && pendQ[i].size() > 0)
      begin
        inFlit[i]  = pendQ[i].pop_front();
        inValid[i] = 1'b1;
        expQ[i].push_back(inFlit[i]);
        credit[i]--;
        sentCnt[i]++;
        occ[i]++;
      end
    end
    if (outValid)
    begin
      due = cycle + delayTab[cycle % 1024];   // Frees the flit 0 to 3 cycles later
      if (due <= lastDue)
        due = lastDue + 1;
      lastDue = due;
      dueQ.push_back(due);
    end
    creditIn = 1'b0;
    if (!holdCredits && dueQ.size() > 0 && dueQ[0] <= cycle)
    begin
      void'(dueQ.pop_front());
      creditIn = 1'b1;
    end
    cycle++;
  end

  // ========================================
  // Compare
  // ========================================

  always @(posedge clk)
  begin
    int   src;
    flitT want;
    if (outValid)
    begin
      src = outFlit.src;
      outCount++;
      assert (src < `NOC_PORTS && expQ[src].size() > 0)
      else
      begin
        $display("A flit tagged with source %0d arrived with none expected at %0t", src, $time);
        errors++;
      end
      if (src < `NOC_PORTS && expQ[src].size() > 0)
      begin
        want = expQ[src].pop_front();
        assert (outFlit.flit == want)
        else
        begin
          $display("[ERROR] %0t outFlit.flit got %h expected %h", $time, outFlit.flit, want);
          errors++;
        end
        if (src != lastSrc)
        begin
          if (lastSrc >= 0 && othersWaiting(lastSrc, lastReq))
          begin
            rotChecks++;
            assert (src == refNextGrant(lastSrc, lastReq))
            else
            begin
              $display("[ERROR] %0t outFlit.src got %0d expected %0d", $time, src,
                       refNextGrant(lastSrc, lastReq));
              errors++;
            end
          end
          runLen = 1;
        end
        else if (lastReq[src])
        begin
          assert (!overBudget(src, lastReq))
          else
          begin
            $display("Source %0d sent more than %0d flits while others waited, at %0t",
                     src, limitOf[src], $time);
            errors++;
          end
          runLen = (runLen == limitOf[src]) ? 1 : runLen + 1;
        end
        else
          runLen = 1;   // Queue ran dry, fresh grant
        if (want.kind == FLIT_HEAD)
        begin
          limitOf[src] = refBudget(want);
          runLen       = 1;
        end
        lastSrc = src;
        lastReq = reqSnap;
      end
    end
  end

  task automatic queuePacket(int port, int bodies, int budget);
    flitT f;
    f.kind    = FLIT_HEAD;
    f.payload = payloadT'($urandom);
    f.payload[`NOC_LEN_W-1:0] = holdLenT'(budget);
    pendQ[port].push_back(f);
    for (int b = 0; b <= bodies; b++)
    begin
      f.kind    = (b == bodies) ? FLIT_TAIL : FLIT_BODY;
      f.payload = payloadT'($urandom);
      pendQ[port].push_back(f);
    end
  endtask

  function automatic bit allDrained();
    for (int i = 0; i < `NOC_PORTS; i++)
    begin
      if (pendQ[i].size() != 0 || expQ[i].size() != 0)
        return 1'b0;
    end
    return 1'b1;
  endfunction

  task automatic waitDrain(int limit);
    int c;
    c = 0;
    while (!allDrained() && c < limit)
    begin
      @(negedge clk);
      c++;
    end
    if (!allDrained())
    begin
      $display("Timed out after %0d cycles with flits still expected", limit);
      $display("Simulation failed");
      $finish;
    end
  endtask

  task automatic finishTest(string name, int errBefore);
    for (int i = 0; i < `NOC_PORTS; i++)
    begin
      assert (creditCnt[i] == sentCnt[i])
      else
      begin
        $display("[ERROR] %0t creditOut[%0d] pulses got %0d expected %0d", $time, i,
                 creditCnt[i], sentCnt[i]);
        errors++;
      end
    end
    testsRun++;
    if (errors != errBefore)
      testsFailed++;
    $display("Test %0d %s: %s", testsRun, name, (errors == errBefore) ? "ok" : "FAILED");
  endtask

  initial
  begin
    int errBefore;
    int mark;
    void'($urandom(51));
    foreach (delayTab[k])
      delayTab[k] = $urandom_range(3, 0);
    clk      = 1'b0;
    rst      = 1'b1;
    inValid  = '0;
    creditIn = 1'b0;
    for (int i = 0; i < `NOC_PORTS; i++)
    begin
      inFlit[i] = '0;
      credit[i] = `NOC_QDEPTH;
    end
    repeat (16) @(negedge clk);
    rst = 1'b0;

    errBefore = errors;
    for (int c = 0; c < 10; c++)
    begin
      @(negedge clk);
      assert (!outValid)
      else
      begin
        $display("outValid rose with no traffic at %0t", $time);
        errors++;
      end
    end
    @(posedge clk);
    queuePacket(PORT_N, 5, 3);
    waitDrain(2000);
    finishTest("single source", errBefore);

    errBefore = errors;
    @(posedge clk);
    for (int p = 0; p < `NOC_PORTS; p++)
    begin
      queuePacket(p, 6, p);   // Budgets 0 to 4
      queuePacket(p, 4, 2);
    end
    waitDrain(5000);
    finishTest("budget hold", errBefore);

    errBefore = errors;
    mark      = rotChecks;
    @(posedge clk);
    for (int n = 0; n < 15; n++)
      queuePacket(n % `NOC_PORTS, 2, 1);
    waitDrain(5000);
    assert (rotChecks > mark)
    else
    begin
      $display("No grant change was seen while several inputs requested");
      errors++;
    end
    finishTest("rotation", errBefore);

    errBefore = errors;
    @(posedge clk);
    holdCredits = 1'b1;
    queuePacket(PORT_E, 4, 2);
    queuePacket(PORT_S, 4, 5);
    @(negedge clk);
    mark = outCount;
    repeat (40) @(negedge clk);
    assert (outCount - mark <= `NOC_QDEPTH)
    else
    begin
      $display("[ERROR] %0t outValid count got %0d expected at most %0d", $time,
               outCount - mark, `NOC_QDEPTH);
      errors++;
    end
    @(posedge clk);
    holdCredits = 1'b0;
    waitDrain(2000);
    finishTest("back-pressure", errBefore);

    errBefore = errors;
    @(posedge clk);
    for (int n = 0; n < 2000; n++)
      queuePacket($urandom_range(4, 0), $urandom_range(3, 0), $urandom_range(7, 0));
    waitDrain(100000);
    finishTest("random mix", errBefore);

    $display("Tests run %0d, failed %0d, errors %0d", testsRun, testsFailed, errors);
    if (errors == 0)
      $display("Simulation passed");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

/* routerOutPort.f */
+incdir+design
+incdir+sim
design/arbPkg.sv
design/flitPkg.sv
design/inputQueue.sv
design/flitDecoder.sv
design/holdTimer.sv
design/portArbiter.sv
design/outputStage.sv
design/routerOutPort.sv
sim/routerOutPortTb.sv
